//--- tb.f
+incdir+verilog
verilog/ein_frame_pkg.sv
verilog/ein_ctrl_pkg.sv
verilog/frame_buffer.sv
verilog/header_decoder.sv
verilog/ein_mod.sv
verilog/ack_generator.sv
verilog/ein_int.sv
testbench/ein_int_props.sv
testbench/ein_int_tb.sv

//--- testbench/ein_int_tb.sv
`timescale 1ns/1ns
`include "ein_macros.svh"

module ein_int_tb import ein_frame_pkg::*; ;

	localparam int NUM_TESTS = 8;

	logic     reset;   // Clock.
	logic     clk;     // Asynchronous reset, active high.
	logic     goc_mode;
	clk_div_t clk_div;
	byte_t    ma_data;
	logic     ma_data_valid;
	logic     ma_frame_valid;
	logic     overflow;
	logic     emo_pad;
	logic     edi_pad;
	logic     eci_pad;
	byte_t    out_data;
	logic     out_data_valid;
	logic     out_frame_valid;

	eid_t     tbl_eid   [NUM_TESTS];
	byte_t    tbl_flags [NUM_TESTS];
	int       tbl_len   [NUM_TESTS];   // Whole frame in bytes, header included.
	logic     tbl_goc   [NUM_TESTS];
	clk_div_t tbl_div   [NUM_TESTS];
	logic     tbl_ovf   [NUM_TESTS];   // A second frame follows and must be dropped.
	logic     table_ready = 1'b0;

	byte_t       frame_bytes [64];
	byte_t       exp_payload [64];
	logic [31:0] rng;
	logic [1:0]  sym_q [$];            // 1 and 0 are data bits, 2 is an ECI mark.
	int          stamp_q [$];
	byte_t       ack_q [$];
	int          cycle = 0;
	int          ack_frames;
	int          ack_start;
	int          ovf_count;
	int          checks;
	int          errors;
	int          test_errors;
	int          cur_test;
	logic        prev_emo;
	logic        prev_edi;
	logic        prev_eci;
	logic        prev_ofv;

	ein_int u_dut (
		.reset           (reset),
		.clk             (clk),
		.goc_mode        (goc_mode),
		.clk_div         (clk_div),
		.ma_data         (ma_data),
		.ma_data_valid   (ma_data_valid),
		.ma_frame_valid  (ma_frame_valid),
		.overflow        (overflow),
		.emo_pad         (emo_pad),
		.edi_pad         (edi_pad),
		.eci_pad         (eci_pad),
		.out_data        (out_data),
		.out_data_valid  (out_data_valid),
		.out_frame_valid (out_frame_valid)
	);

	initial begin
		reset = 1'b0;
		forever #10 reset = ~reset;
	end

	////////////////////
	// Helpers.
	////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Cycles per symbol, with small dividers raised to the minimum.
	function automatic int symbol_cycles(input clk_div_t div);
		return (div < `EIN_MIN_DIV) ? `EIN_MIN_DIV : int'(div);
	endfunction

	function automatic int payload_len(input int len);
		return (len > `EIN_HDR_LEN) ? len - `EIN_HDR_LEN : 0;
	endfunction

	task automatic add_entry(input int idx, input eid_t eid, input byte_t flags, input int len,
			input logic goc, input clk_div_t div, input logic ovf);
		tbl_eid[idx]   = eid;
		tbl_flags[idx] = flags;
		tbl_len[idx]   = len;
		tbl_goc[idx]   = goc;
		tbl_div[idx]   = div;
		tbl_ovf[idx]   = ovf;
	endtask

	task automatic report_error(input string msg);
		errors++;
		test_errors++;
		$display("test %0d: %s", cur_test, msg);
	endtask

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_eid(input string name, input eid_t got, input eid_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	// Header first, then payload bytes from the random sequence.
	task automatic build_frame(input int t);
		frame_bytes[0] = tbl_eid[t];
		frame_bytes[1] = tbl_flags[t];
		for (int i = `EIN_HDR_LEN; i < tbl_len[t]; i++) begin
			rng = xorshift32(rng);
			frame_bytes[i] = rng[7:0];
			exp_payload[i - `EIN_HDR_LEN] = rng[7:0];
		end
	endtask

	task automatic send_frame(input int n);
		@(posedge reset) ma_frame_valid <= 1'b1;
		for (int i = 0; i < n; i++) begin
			@(posedge reset);
			ma_data       <= frame_bytes[i];
			ma_data_valid <= 1'b1;
		end
		@(posedge reset) ma_data_valid <= 1'b0;
		@(posedge reset) ma_frame_valid <= 1'b0;
	endtask

	task automatic wait_ack(input int limit);
		int n;
		n = 0;
		while (ack_frames == 0 && n < limit) begin
			@(posedge reset);
			n++;
		end
		if (ack_frames == 0)
			report_error($sformatf("no acknowledge arrived within %0d cycles", limit));
		repeat (4) @(posedge reset);   // Room for any extra strobe to show up.
	endtask

	task automatic check_pads(input int plen, input logic goc, input logic frag, input int eff);
		int    pos;
		int    marks;
		int    exp_total;
		int    gap;
		int    min_gap;
		int    max_gap;
		byte_t val;
		pos       = 0;
		exp_total = plen * 9 - 1 + (frag ? 1 : 2);
		if (sym_q.size() != exp_total) begin
			report_error($sformatf("%0d pad symbols seen where %0d were expected",
				sym_q.size(), exp_total));
		end else begin
			for (int i = 0; i < plen; i++) begin
				val = '0;
				for (int b = 0; b < 8; b++) begin
					if (sym_q[pos] == 2'd2)
						report_error($sformatf("ECI mark inside payload byte %0d", i));
					if (goc)
						val[b] = sym_q[pos][0];       // LSB first.
					else
						val[7 - b] = sym_q[pos][0];
					pos++;
				end
				check_byte("payload byte", val, exp_payload[i]);
				marks = 0;
				while (pos < sym_q.size() && sym_q[pos] == 2'd2) begin
					marks++;
					pos++;
				end
				check_byte("eci marks", byte_t'(marks),
					(i == plen - 1) ? (frag ? 8'd1 : 8'd2) : 8'd1);
			end
			min_gap = 1 << 30;
			max_gap = 0;
			for (int i = 1; i < stamp_q.size(); i++) begin
				gap = stamp_q[i] - stamp_q[i - 1];
				if (gap < min_gap) min_gap = gap;
				if (gap > max_gap) max_gap = gap;
			end
			check_byte("symbol period min", byte_t'(min_gap), byte_t'(eff));
			check_byte("symbol period max", byte_t'(max_gap), byte_t'(eff));
		end
	endtask

	task automatic check_ack(input eid_t eid, input int eff);
		check_byte("ack frames", byte_t'(ack_frames), 8'd1);
		check_byte("ack strobes", byte_t'(ack_q.size()), 8'd2);
		if (ack_q.size() >= 2) begin
			check_eid("ack eid", ack_q[0], eid);
			check_byte("ack code", ack_q[1], `EIN_ACK_CODE);
		end
		// The ack must start after the last pad edge and close behind it.
		if (ack_frames > 0 && stamp_q.size() > 0)
			check_bit("ack latency in bound",
				(ack_start > stamp_q[$]) && ((ack_start - stamp_q[$]) <= eff + 6), 1'b1);
	endtask

	////////////////////
	// Monitors.
	////////////////////

	always @(posedge reset) cycle <= cycle + 1;

	// Sampled on the falling edge, half a period after the outputs move.
	always @(negedge reset) begin
		if (!clk) begin
			if (emo_pad !== prev_emo) begin
				sym_q.push_back(2'd1);
				stamp_q.push_back(cycle);
			end
			if (edi_pad !== prev_edi) begin
				sym_q.push_back(2'd0);
				stamp_q.push_back(cycle);
			end
			if (eci_pad !== prev_eci) begin
				sym_q.push_back(2'd2);
				stamp_q.push_back(cycle);
			end
			if (out_frame_valid && !prev_ofv) ack_start = cycle;
			if (!out_frame_valid && prev_ofv) ack_frames++;
			if (out_data_valid) ack_q.push_back(out_data);
			if (overflow) ovf_count++;
		end
		prev_emo = emo_pad;
		prev_edi = edi_pad;
		prev_eci = eci_pad;
		prev_ofv = out_frame_valid;
	end

	initial begin
		int limit_ns;
		wait (table_ready);
		limit_ns = 40000;
		for (int k = 0; k < NUM_TESTS; k++)
			limit_ns += (payload_len(tbl_len[k]) * 9 + 40) * symbol_cycles(tbl_div[k]) * 20;
		#(limit_ns);
		$display("timeout: the tests did not finish within %0d ns", limit_ns);
		$display("FAIL: see errors above");
		$finish;
	end

	////////////////////
	// Test sequence.
	////////////////////

	initial begin
		int plen;
		int eff;
		clk            = 1'b1;
		goc_mode       = 1'b0;
		clk_div        = 32'd4;
		ma_data        = '0;
		ma_data_valid  = 1'b0;
		ma_frame_valid = 1'b0;
		rng            = 32'hbe28_0786;
		checks         = 0;
		errors         = 0;
		add_entry(0, 8'h21, 8'h00, 5, 1'b0, 32'd4, 1'b0);
		add_entry(1, 8'h3c, 8'h01, 4, 1'b1, 32'd6, 1'b0);   // Fragment, one end mark.
		add_entry(2, 8'h5a, 8'h00, 1, 1'b0, 32'd4, 1'b0);   // Eid only.
		add_entry(3, 8'h77, 8'h00, 3, 1'b1, 32'd2, 1'b0);
		add_entry(4, 8'h81, 8'h00, 2, 1'b0, 32'd5, 1'b0);   // Header only.
		add_entry(5, 8'h9e, 8'h01, 6, 1'b0, 32'd0, 1'b0);
		add_entry(6, 8'ha4, 8'h00, 4, 1'b1, 32'd5, 1'b1);
		add_entry(7, 8'hc3, 8'h00, 3, 1'b0, 32'd7, 1'b0);
		table_ready = 1'b1;

		repeat (8) @(posedge reset);
		clk <= 1'b0;
		repeat (2) @(posedge reset);

		for (int t = 0; t < NUM_TESTS; t++) begin
			cur_test    = t;
			test_errors = 0;
			plen        = payload_len(tbl_len[t]);
			eff         = symbol_cycles(tbl_div[t]);
			sym_q.delete();
			stamp_q.delete();
			ack_q.delete();
			ack_frames = 0;
			ovf_count  = 0;
			@(posedge reset);
			goc_mode <= tbl_goc[t];
			clk_div  <= tbl_div[t];
			build_frame(t);
			send_frame(tbl_len[t]);
			if (tbl_ovf[t]) begin
				repeat (2) @(posedge reset);
				for (int i = 0; i < tbl_len[t]; i++) begin
					rng = xorshift32(rng);
					frame_bytes[i] = rng[7:0];
				end
				send_frame(tbl_len[t]);
			end
			if (plen > 0) begin
				wait_ack(eff * (plen * 9 + 2) + 100);
				check_pads(plen, tbl_goc[t], tbl_flags[t][0], eff);
				check_ack(tbl_eid[t], eff);
			end else begin
				repeat (100) @(posedge reset);   // A short frame must stay silent.
				check_byte("pad symbols", byte_t'(sym_q.size()), 8'd0);
				check_byte("ack frames", byte_t'(ack_frames), 8'd0);
			end
			check_byte("overflow pulses", byte_t'(ovf_count), byte_t'(tbl_ovf[t]));
			$display("test %0d done: eid 0x%h, %0d payload bytes, %0d errors",
				t, tbl_eid[t], plen, test_errors);
		end

		$display("summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- testbench/ein_int_props.sv
`timescale 1ns/1ns

module ein_int_props (
	input logic reset,
	input logic clk,
	input logic emo_pad,
	input logic edi_pad,
	input logic eci_pad,
	input logic overflow,
	input logic out_data_valid,
	input logic out_frame_valid
);

	// A symbol period moves one pad at most.
	a_one_pad: assert property (@(posedge reset) disable iff (clk)
		$onehot0({$changed(emo_pad), $changed(edi_pad), $changed(eci_pad)}))
		else $error("more than one pad changed in one cycle");

	a_strobe_in_frame: assert property (@(posedge reset) disable iff (clk)
		out_data_valid |-> out_frame_valid)
		else $error("ack strobe outside the ack frame level");   // Strobes sit inside the level.

	// From the second cycle of reset on, all strobes and levels are low.
	a_quiet_reset: assert property (@(posedge reset)
		(clk && $past(clk)) |-> !(overflow || out_data_valid || out_frame_valid))
		else $error("strobe active while reset is held");

endmodule

bind ein_int ein_int_props u_props (.*);

//--- verilog/ein_int.sv
`timescale 1ns/1ns

module ein_int import ein_frame_pkg::*, ein_ctrl_pkg::*; (
	input  logic     reset,
	input  logic     clk,
	input  logic     goc_mode,
	input  clk_div_t clk_div,
	input  byte_t    ma_data,
	input  logic     ma_data_valid,
	input  logic     ma_frame_valid,
	output logic     overflow,
	output logic     emo_pad,
	output logic     edi_pad,
	output logic     eci_pad,
	output byte_t    out_data,
	output logic     out_data_valid,
	output logic     out_frame_valid
);

	char_t       fb_dout;
	logic        fb_frame_valid;
	logic        fb_re;
	eid_t        hd_eid;
	logic        hd_fragment;
	logic        hd_header_done;
	logic        mod_re;
	logic        generate_ack;
	link_state_t state;
	link_state_t next_state;

	frame_buffer u_buf (
		.reset          (reset),
		.clk            (clk),
		.ma_data        (ma_data),
		.ma_data_valid  (ma_data_valid),
		.ma_frame_valid (ma_frame_valid),
		.fifo_re        (fb_re),
		.fifo_dout      (fb_dout),
		.frame_valid    (fb_frame_valid),
		.overflow       (overflow)
	);

	header_decoder u_hd (
		.reset       (reset),
		.clk         (clk),
		.fifo_dout   (fb_dout),
		.frame_valid (fb_frame_valid),
		.mod_re      (mod_re),
		.fifo_re     (fb_re),
		.eid         (hd_eid),
		.fragment    (hd_fragment),
		.header_done (hd_header_done)
	);

	// One pad changes per symbol period.
	ein_mod u_mod (
		.reset    (reset),
		.clk      (clk),
		.clk_div  (clk_div),
		.goc_mode (goc_mode),
		.fragment (hd_fragment),
		.start_tx (hd_header_done),
		.fifo_din (fb_dout),
		.fifo_re  (mod_re),
		.emo_out  (emo_pad),
		.edi_out  (edi_pad),
		.eci_out  (eci_pad)
	);

	ack_generator u_ack (
		.reset               (reset),
		.clk                 (clk),
		.generate_ack        (generate_ack),
		.eid_in              (hd_eid),
		.message_data        (out_data),
		.message_data_valid  (out_data_valid),
		.message_frame_valid (out_frame_valid)
	);

	////////////////////
	// Link sequencing.
	////////////////////

	// The fall of header_done means the modulator has released the last character.
	always_comb begin
		next_state   = state;
		generate_ack = 1'b0;
		case (state)
			LINK_IDLE: if (hd_header_done) next_state = LINK_TX;
			LINK_TX:   if (!hd_header_done) next_state = LINK_ACK;
			LINK_ACK: begin
				generate_ack = 1'b1;   // Single cycle request.
				next_state   = LINK_IDLE;
			end
			default: next_state = LINK_IDLE;
		endcase
	end

	always_ff @(posedge reset or posedge clk) begin
		if (clk)
			state <= LINK_IDLE;
		else
			state <= next_state;
	end

endmodule

//--- verilog/ack_generator.sv
`timescale 1ns/1ns
`include "ein_macros.svh"

module ack_generator import ein_frame_pkg::*, ein_ctrl_pkg::*; (
	input  logic  reset,
	input  logic  clk,
	input  logic  generate_ack,
	input  eid_t  eid_in,
	output byte_t message_data,
	output logic  message_data_valid,
	output logic  message_frame_valid
);

	ack_state_t state;
	eid_t       eid_q;   // Endpoint id captured on the request.

	always_ff @(posedge reset) begin
		if (generate_ack && state == ACK_IDLE)
			eid_q <= eid_in;
		if (state == ACK_EID)
			message_data <= eid_q;
		else if (state == ACK_CODE)
			message_data <= `EIN_ACK_CODE;
	end

	// The frame level opens one cycle ahead of the first strobe and closes after the second.
	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			state               <= ACK_IDLE;
			message_data_valid  <= 1'b0;
			message_frame_valid <= 1'b0;
		end else begin
			case (state)
				ACK_IDLE: begin
					message_data_valid  <= 1'b0;
					message_frame_valid <= generate_ack;
					if (generate_ack)
						state <= ACK_EID;
				end
				ACK_EID: begin
					message_data_valid <= 1'b1;
					state              <= ACK_CODE;
				end
				ACK_CODE: begin
					message_data_valid <= 1'b1;
					state              <= ACK_IDLE;
				end
				default: state <= ACK_IDLE;
			endcase
		end
	end

endmodule

//--- verilog/ein_mod.sv
`timescale 1ns/1ns
`include "ein_macros.svh"

module ein_mod import ein_frame_pkg::*, ein_ctrl_pkg::*; (
	input  logic     reset,
	input  logic     clk,
	input  clk_div_t clk_div,
	input  logic     goc_mode,
	input  logic     fragment,
	input  logic     start_tx,
	input  char_t    fifo_din,
	output logic     fifo_re,
	output logic     emo_out,
	output logic     edi_out,
	output logic     eci_out
);

	mod_state_t state;
	clk_div_t   eff_div;
	clk_div_t   div_cnt;
	byte_t      shreg;
	logic [2:0] bit_cnt;
	logic       last;        // The byte in the shift register ends the frame.
	logic       tick;
	logic       cur_bit;

	////////////////////
	// Symbol timing.
	////////////////////

	assign eff_div = (clk_div < `EIN_MIN_DIV) ? clk_div_t'(`EIN_MIN_DIV) : clk_div;

	// End of a symbol period. Every pad change happens on one of these.
	assign tick = (state != MOD_IDLE) && (state != MOD_LOAD) && (div_cnt >= eff_div - 1'b1);

	assign cur_bit = goc_mode ? shreg[0] : shreg[7];

	// A character is released from the buffer only once its last symbol is out.
	// For the final byte that is after the end marks, which lets the ack follow the pads.
	always_comb begin
		fifo_re = 1'b0;
		if (tick) begin
			case (state)
				MOD_BITS: fifo_re = (bit_cnt == 3'd7) && !last;
				MOD_END1: fifo_re = fragment;
				MOD_END2: fifo_re = 1'b1;
				default:  fifo_re = 1'b0;
			endcase
		end
	end

	always_ff @(posedge reset) begin
		if (state == MOD_LOAD || (state == MOD_SEP && tick))
			shreg <= fifo_din[7:0];
		else if (state == MOD_BITS && tick)
			shreg <= goc_mode ? {1'b0, shreg[7:1]} : {shreg[6:0], 1'b0};
	end

	////////////////////
	// Control and pads.
	////////////////////

	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			state   <= MOD_IDLE;
			div_cnt <= '0;
			bit_cnt <= '0;
			last    <= 1'b0;
			emo_out <= 1'b0;
			edi_out <= 1'b0;
			eci_out <= 1'b0;
		end else begin
			if (state == MOD_IDLE || state == MOD_LOAD)
				div_cnt <= '0;
			else
				div_cnt <= tick ? '0 : div_cnt + 1'b1;

			case (state)
				MOD_IDLE: begin
					if (start_tx)
						state <= MOD_LOAD;
				end
				MOD_LOAD: begin
					bit_cnt <= '0;
					last    <= fifo_din[8];
					state   <= MOD_BITS;
				end
				MOD_BITS: begin
					if (tick) begin
						if (cur_bit)
							emo_out <= ~emo_out;   // A one bit.
						else
							edi_out <= ~edi_out;   // A zero bit.
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= last ? MOD_END1 : MOD_SEP;
					end
				end
				MOD_SEP: begin
					// The next character is already visible, so it loads on the separator.
					if (tick) begin
						eci_out <= ~eci_out;
						bit_cnt <= '0;
						last    <= fifo_din[8];
						state   <= MOD_BITS;
					end
				end
				MOD_END1: begin
					if (tick) begin
						eci_out <= ~eci_out;
						state   <= fragment ? MOD_IDLE : MOD_END2;
					end
				end
				MOD_END2: begin
					if (tick) begin
						eci_out <= ~eci_out;
						state   <= MOD_IDLE;
					end
				end
				default: state <= MOD_IDLE;
			endcase
		end
	end

endmodule

//--- verilog/header_decoder.sv
`timescale 1ns/1ns

module header_decoder import ein_frame_pkg::*, ein_ctrl_pkg::*; (
	input  logic  reset,
	input  logic  clk,
	input  char_t fifo_dout,
	input  logic  frame_valid,
	input  logic  mod_re,
	output logic  fifo_re,
	output eid_t  eid,
	output logic  fragment,
	output logic  header_done
);

	hd_state_t state;
	logic      hd_re;
	logic      is_mark;

	assign is_mark = fifo_dout[8];

	// Header characters are read here. A marked header character is left for the drop state.
	always_comb begin
		case (state)
			HD_EID, HD_FLAGS: hd_re = !is_mark;
			HD_DROP:          hd_re = frame_valid;
			default:          hd_re = 1'b0;
		endcase
	end

	assign header_done = (state == HD_PAYLOAD);
	assign fifo_re     = header_done ? mod_re : hd_re;   // The modulator owns the payload reads.

	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			state    <= HD_WAIT;
			eid      <= '0;
			fragment <= 1'b0;
		end else begin
			case (state)
				HD_WAIT: begin
					if (frame_valid)
						state <= HD_EID;
				end
				HD_EID: begin
					if (is_mark) begin
						state <= HD_DROP;   // Frame of one byte.
					end else begin
						eid   <= fifo_dout[7:0];
						state <= HD_FLAGS;
					end
				end
				HD_FLAGS: begin
					if (is_mark) begin
						state <= HD_DROP;   // Header with no payload behind it.
					end else begin
						fragment <= fifo_dout[0];
						state    <= HD_PAYLOAD;
					end
				end
				HD_PAYLOAD: begin
					if (mod_re && is_mark)
						state <= HD_WAIT;
				end
				HD_DROP: begin
					// Keep reading until the end mark has gone.
					if (!frame_valid || is_mark)
						state <= HD_WAIT;
				end
				default: state <= HD_WAIT;
			endcase
		end
	end

endmodule

//--- verilog/frame_buffer.sv
`timescale 1ns/1ns
`include "ein_macros.svh"

module frame_buffer import ein_frame_pkg::*; (
	input  logic  reset,
	input  logic  clk,
	input  byte_t ma_data,
	input  logic  ma_data_valid,
	input  logic  ma_frame_valid,
	input  logic  fifo_re,
	output char_t fifo_dout,
	output logic  frame_valid,
	output logic  overflow
);

	char_t     mem [`EIN_BUF_DEPTH];
	buf_addr_t wr_ptr;
	buf_addr_t rd_ptr;
	byte_t     last_byte;     // Copy of the newest byte, rewritten with the end mark.
	logic      fv_q;
	logic      dropping;      // The current host frame is being thrown away.
	logic      has_bytes;

	logic      frame_rise;
	logic      frame_fall;
	logic      reject;
	logic      accept;
	logic      wr_en;
	buf_addr_t wr_addr;
	char_t     wr_data;

	assign frame_rise = ma_frame_valid & ~fv_q;
	assign frame_fall = ~ma_frame_valid & fv_q;
	assign reject     = frame_rise & frame_valid;   // A frame is still held.
	assign accept     = ma_frame_valid & ~dropping & ~reject;

	// The close of a frame and a new byte never share a cycle, so one write port is enough.
	always_comb begin
		wr_en   = 1'b0;
		wr_addr = frame_rise ? '0 : wr_ptr;
		wr_data = {1'b0, ma_data};
		if (frame_fall && !dropping && has_bytes) begin
			wr_en   = 1'b1;
			wr_addr = wr_ptr - 1'b1;
			wr_data = {1'b1, last_byte};
		end else if (ma_data_valid && accept) begin
			wr_en = 1'b1;
		end
	end

	always_ff @(posedge reset) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		if (ma_data_valid && accept)
			last_byte <= ma_data;
	end

	assign fifo_dout = mem[rd_ptr];   // Oldest unread character.

	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			fv_q        <= 1'b0;
			dropping    <= 1'b0;
			has_bytes   <= 1'b0;
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			frame_valid <= 1'b0;
			overflow    <= 1'b0;
		end else begin
			fv_q     <= ma_frame_valid;
			overflow <= reject;
			if (reject)
				dropping <= 1'b1;
			else if (frame_fall)
				dropping <= 1'b0;
			if (frame_rise && !reject) begin
				wr_ptr    <= '0;
				rd_ptr    <= '0;
				has_bytes <= 1'b0;
			end
			if (ma_data_valid && accept) begin
				wr_ptr    <= wr_addr + 1'b1;
				has_bytes <= 1'b1;
			end
			// Reading the end mark empties the buffer.
			if (frame_fall && !dropping && has_bytes)
				frame_valid <= 1'b1;
			else if (fifo_re && frame_valid && fifo_dout[8])
				frame_valid <= 1'b0;
			if (fifo_re && frame_valid)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

//--- verilog/ein_ctrl_pkg.sv
// State encodings of the control machines.
package ein_ctrl_pkg;

	// Top level link sequencing.
	typedef enum logic [1:0] {
		LINK_IDLE, LINK_TX, LINK_ACK
	} link_state_t;

	// Header decoder. The drop state drains frames that end inside the header.
	typedef enum logic [2:0] {
		HD_WAIT, HD_EID, HD_FLAGS, HD_PAYLOAD, HD_DROP
	} hd_state_t;

	// Pad modulator.
	typedef enum logic [2:0] {
		MOD_IDLE, MOD_LOAD, MOD_BITS, MOD_SEP, MOD_END1, MOD_END2
	} mod_state_t;

	typedef enum logic [1:0] {
		ACK_IDLE, ACK_EID, ACK_CODE
	} ack_state_t;   // Acknowledge message player.

endpackage

//--- verilog/ein_frame_pkg.sv
`include "ein_macros.svh"

// Data types that travel between the frame buffer, the decoder and the modulator.
package ein_frame_pkg;

	// One byte as it appears on the host bus or the ack bus.
	typedef logic [7:0] byte_t;

	// A buffered character. Bit 8 marks the last character of a frame.
	typedef logic [8:0] char_t;

	typedef logic [`EIN_BUF_AW-1:0] buf_addr_t;   // Read or write pointer into the buffer.

	// Endpoint id, taken from the first header byte.
	typedef logic [7:0] eid_t;

	// Clock cycles per symbol period on the pads.
	typedef logic [31:0] clk_div_t;

endpackage

//--- verilog/ein_macros.svh
`ifndef EIN_MACROS_SVH
`define EIN_MACROS_SVH

////////////////////
// Frame buffer sizing.
////////////////////

// Number of characters the frame buffer can hold.
`define EIN_BUF_DEPTH 512

// Address width that matches the buffer depth.
`define EIN_BUF_AW 9

////////////////////
// Link protocol constants.
////////////////////

`define EIN_HDR_LEN 2     // Header bytes in front of the payload, eid then flags.

// Second byte of every acknowledge message.
`define EIN_ACK_CODE 8'h06

`define EIN_MIN_DIV 4     // Smaller dividers are raised to this value.

`endif
